//--- chart_pkg.sv
`default_nettype none

package chart_pkg;

    // Depth of the chart memory
    localparam int unsigned CHART_LEN_MAX = 64;

    // Keys are one-hot with C at bit 0, all zero is a rest
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;
    } note_t;

    typedef logic [13:0] score_t;

    typedef logic [1:0] digit_t;

    // Bit 0 is octave shifted, bits 7 down to 1 are keys C to B
    typedef logic [7:0] led_t;

    typedef logic [$clog2(CHART_LEN_MAX)-1:0] idx_t;

    // Timing window points
    localparam score_t PERFECT_PTS = 14'd10;
    localparam score_t GREAT_PTS   = 14'd8;
    localparam score_t GOOD_PTS    = 14'd5;

endpackage

`default_nettype wire

//--- tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int unsigned DIV = 10
) (
    input  logic prog_clk,
    input  logic rst,
    output logic tick
);
    localparam int unsigned CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            // Tick lands the cycle after the count wraps
            tick <= (cnt == LAST);
            if (cnt == LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    generate
        if (DIV > 1) begin : g_tick_chk
            a_tick_single: assert property (
                @(posedge prog_clk) disable iff (rst) tick |=> !tick
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- count_down.sv
`timescale 1ns/1ps
`default_nettype none

module count_down #(
    parameter int unsigned DIGIT_STEPS = 10
) (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             start,
    input  logic             step_tick,
    output chart_pkg::digit_t digit,
    output logic             play_st
);
    localparam int unsigned STEP_W = (DIGIT_STEPS > 1) ? $clog2(DIGIT_STEPS) : 1;
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(DIGIT_STEPS - 1);

    logic [STEP_W-1:0] step_cnt;
    logic              counting;

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            step_cnt <= '0;
            counting <= 1'b0;
            digit    <= 2'd3;
            play_st  <= 1'b0;
        end else if (start) begin
            step_cnt <= '0;
            counting <= 1'b1;
            digit    <= 2'd3;
            play_st  <= 1'b0;
        end else if (counting && step_tick) begin
            if (step_cnt == STEP_LAST) begin
                step_cnt <= '0;
                // Digit 0 also lasts a full period before play
                if (digit == 2'd0) begin
                    counting <= 1'b0;
                    play_st  <= 1'b1;
                end else begin
                    digit <= digit - 2'd1;
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    a_digit_hold: assert property (
        @(posedge prog_clk) disable iff (rst) (play_st && !start) |=> $stable(digit)
    );

endmodule

`default_nettype wire

//--- chart_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module chart_sequencer (
    input  logic             prog_clk,
    input  logic             rst,
    input  logic             start,
    input  logic             step_tick,
    input  logic             play_st,
    input  logic             load_en,
    input  chart_pkg::idx_t  load_addr,
    input  chart_pkg::note_t load_note,
    input  chart_pkg::idx_t  note_total,
    output chart_pkg::note_t cur_note,
    output logic             done,
    output logic             playing
);
    chart_pkg::note_t chart_mem [chart_pkg::CHART_LEN_MAX];
    chart_pkg::idx_t  note_idx;

    assign playing = play_st && !done;

    // Chart load port
    always_ff @(posedge prog_clk) begin
        if (load_en) begin
            chart_mem[load_addr] <= load_note;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (rst || start) begin
            note_idx <= '0;
            cur_note <= '0;
            done     <= 1'b0;
        end else if (playing && step_tick) begin
            if (note_idx == note_total) begin
                // Past the last note
                cur_note <= '0;
                done     <= 1'b1;
            end else begin
                cur_note <= chart_mem[note_idx];
                note_idx <= note_idx + 1'b1;
            end
        end
    end

    a_no_load_in_play: assert property (
        @(posedge prog_clk) disable iff (rst) load_en |-> !playing
    );

    // Index never runs past the chart length
    a_idx_bound: assert property (
        @(posedge prog_clk) disable iff (rst) playing |-> (note_idx <= note_total)
    );

endmodule

`default_nettype wire

//--- score_judge.sv
`timescale 1ns/1ps
`default_nettype none

module score_judge (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              start,
    input  logic              scan_tick,
    input  logic              playing,
    input  chart_pkg::note_t  cur_note,
    input  chart_pkg::note_t  keys,
    output chart_pkg::score_t score
);
    chart_pkg::note_t  hist_1;
    chart_pkg::note_t  hist_2;
    chart_pkg::note_t  hist_3;
    chart_pkg::score_t pts;
    logic [14:0]       sum;

    // Window points for the current note
    always_comb begin
        pts = '0;
        if (cur_note != '0) begin
            if (cur_note == keys || cur_note == hist_1) begin
                pts = chart_pkg::PERFECT_PTS;
            end else if (cur_note == hist_2) begin
                pts = chart_pkg::GREAT_PTS;
            end else if (cur_note == hist_3) begin
                pts = chart_pkg::GOOD_PTS;
            end
        end
    end

    assign sum = {1'b0, score} + {1'b0, pts};

    always_ff @(posedge prog_clk) begin
        if (rst || start) begin
            score  <= '0;
            hist_1 <= '0;
            hist_2 <= '0;
            hist_3 <= '0;
        end else if (playing && scan_tick) begin
            // Saturate at the top
            score  <= sum[14] ? '1 : sum[13:0];
            hist_1 <= keys;
            hist_2 <= hist_1;
            hist_3 <= hist_2;
        end
    end

    a_score_monotonic: assert property (
        @(posedge prog_clk) disable iff (rst) !start |=> (score >= $past(score))
    );

endmodule

`default_nettype wire

//--- note_output.sv
`timescale 1ns/1ps
`default_nettype none

module note_output #(
    parameter int unsigned TONE_SCALE = 1
) (
    input  logic             prog_clk,
    input  logic             rst,
    input  chart_pkg::note_t cur_note,
    output logic             sig,
    output chart_pkg::led_t  led
);
    localparam int unsigned HALF_W = 19;

    function automatic int unsigned scaled(input int unsigned cycles);
        return (cycles / TONE_SCALE > 0) ? cycles / TONE_SCALE : 1;
    endfunction

    // Half periods at 100 MHz, low/mid/high sets, keys C to B
    localparam int unsigned HALF_TBL [21] = '{
        scaled(382234), scaled(340530), scaled(303379), scaled(286352),
        scaled(255102), scaled(227273), scaled(202478),
        scaled(191113), scaled(170265), scaled(151686), scaled(143172),
        scaled(127551), scaled(113636), scaled(101239),
        scaled(95557), scaled(85132), scaled(75843), scaled(71586),
        scaled(63776), scaled(56818), scaled(50619)
    };

    logic              valid;
    logic [1:0]        oct_idx;
    logic [2:0]        key_idx;
    logic [4:0]        tbl_idx;
    logic [HALF_W-1:0] half_len;
    logic [HALF_W-1:0] cnt;
    chart_pkg::note_t  note_q;
    chart_pkg::led_t   led_nxt;

    always_comb begin
        valid = (cur_note.keys != 7'd0)
            && ((cur_note.keys & (cur_note.keys - 7'd1)) == 7'd0)
            && !(cur_note.oct_down && cur_note.oct_up);

        // Octave bits 01 pick the low set, 10 the high set
        case ({cur_note.oct_down, cur_note.oct_up})
            2'b01:   oct_idx = 2'd0;
            2'b10:   oct_idx = 2'd2;
            default: oct_idx = 2'd1;
        endcase

        key_idx = 3'd0;
        for (int i = 0; i < 7; i++) begin
            if (cur_note.keys[i]) begin
                key_idx = 3'(i);
            end
        end
    end

    assign tbl_idx  = 5'(oct_idx) * 5'd7 + 5'(key_idx);
    assign half_len = HALF_W'(HALF_TBL[tbl_idx]);

    always_comb begin
        led_nxt = '0;
        if (valid) begin
            led_nxt[0] = cur_note.oct_down || cur_note.oct_up;
            for (int i = 0; i < 7; i++) begin
                led_nxt[7 - i] = cur_note.keys[i];
            end
        end
    end

    always_ff @(posedge prog_clk) begin
        if (rst) begin
            cnt    <= '0;
            sig    <= 1'b0;
            note_q <= '0;
            led    <= '0;
        end else begin
            note_q <= cur_note;
            led    <= led_nxt;
            // Restart the wave on a new note, silence on a rest
            if (!valid || cur_note != note_q) begin
                cnt <= '0;
                sig <= 1'b0;
            end else if (cnt == half_len - 1'b1) begin
                cnt <= '0;
                sig <= !sig;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- play_chart.sv
`timescale 1ns/1ps
`default_nettype none

module play_chart #(
    parameter int unsigned STEP_DIV    = 10_000_000,
    parameter int unsigned SCAN_DIV    = STEP_DIV / 2,
    parameter int unsigned DIGIT_STEPS = 10,
    parameter int unsigned TONE_SCALE  = 1
) (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              start,
    input  logic              load_en,
    input  chart_pkg::idx_t   load_addr,
    input  chart_pkg::note_t  load_note,
    input  chart_pkg::idx_t   note_total,
    input  chart_pkg::note_t  keys,
    output chart_pkg::digit_t digit,
    output logic              play_st,
    output chart_pkg::note_t  cur_note,
    output logic              done,
    output chart_pkg::score_t score,
    output logic              sig,
    output chart_pkg::led_t   led
);
    logic step_tick;
    logic scan_tick;
    logic playing;

    tick_divider #(.DIV(STEP_DIV)) u_step_div (
        .prog_clk (prog_clk),
        .rst      (rst),
        .tick     (step_tick)
    );

    tick_divider #(.DIV(SCAN_DIV)) u_scan_div (
        .prog_clk (prog_clk),
        .rst      (rst),
        .tick     (scan_tick)
    );

    count_down #(.DIGIT_STEPS(DIGIT_STEPS)) u_count_down (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .start     (start),
        .step_tick (step_tick),
        .digit     (digit),
        .play_st   (play_st)
    );

    chart_sequencer u_chart_sequencer (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .step_tick  (step_tick),
        .play_st    (play_st),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_note  (load_note),
        .note_total (note_total),
        .cur_note   (cur_note),
        .done       (done),
        .playing    (playing)
    );

    score_judge u_score_judge (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .start     (start),
        .scan_tick (scan_tick),
        .playing   (playing),
        .cur_note  (cur_note),
        .keys      (keys),
        .score     (score)
    );

    note_output #(.TONE_SCALE(TONE_SCALE)) u_note_output (
        .prog_clk (prog_clk),
        .rst      (rst),
        .cur_note (cur_note),
        .sig      (sig),
        .led      (led)
    );

endmodule

`default_nettype wire

//--- tb_play_chart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_play_chart;

    localparam int unsigned STEP_DIV    = 8;
    localparam int unsigned SCAN_DIV    = 4;
    localparam int unsigned DIGIT_STEPS = 2;
    localparam int unsigned TONE_SCALE  = 1000;
    localparam int unsigned RAND_NOTES  = 24;
    localparam int unsigned CD_GAP      = DIGIT_STEPS * STEP_DIV;
    localparam int          SLOT_TOP    = 2 * chart_pkg::CHART_LEN_MAX + 1;
    localparam int unsigned VEC_WORDS   = 2 + 2 * chart_pkg::CHART_LEN_MAX;
    localparam int unsigned LIMIT       =
        2 * (4 * DIGIT_STEPS + chart_pkg::CHART_LEN_MAX + 4) * STEP_DIV;

    logic              prog_clk;
    logic              rst;
    logic              start;
    logic              load_en;
    chart_pkg::idx_t   load_addr;
    chart_pkg::note_t  load_note;
    chart_pkg::idx_t   note_total;
    chart_pkg::note_t  keys;
    chart_pkg::digit_t digit;
    logic              play_st;
    chart_pkg::note_t  cur_note;
    logic              done;
    chart_pkg::score_t score;
    logic              sig;
    chart_pkg::led_t   led;

    logic [11:0]      vec [0:VEC_WORDS-1];
    chart_pkg::note_t chart [chart_pkg::CHART_LEN_MAX];
    int unsigned      key_ofs [chart_pkg::CHART_LEN_MAX];
    // Keys sampled on each scan tick of play, slot 0 on the first step tick
    chart_pkg::note_t key_slot [-3:SLOT_TOP];
    logic [31:0]      rng = 32'd96300;
    int unsigned      run_cycles = 0;
    int unsigned      sig_rises = 0;

    play_chart #(
        .STEP_DIV    (STEP_DIV),
        .SCAN_DIV    (SCAN_DIV),
        .DIGIT_STEPS (DIGIT_STEPS),
        .TONE_SCALE  (TONE_SCALE)
    ) u_play_chart (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_note  (load_note),
        .note_total (note_total),
        .keys       (keys),
        .digit      (digit),
        .play_st    (play_st),
        .cur_note   (cur_note),
        .done       (done),
        .score      (score),
        .sig        (sig),
        .led        (led)
    );

    initial begin
        prog_clk = 1'b0;
        forever #4 prog_clk = ~prog_clk;
    end

    always @(posedge sig) begin
        sig_rises <= sig_rises + 1;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge prog_clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= LIMIT) begin
            $display("run did not finish within %0d cycles", LIMIT);
            abort_run();
        end
    end

    task automatic check_note(input chart_pkg::note_t got, input chart_pkg::note_t want,
                              input string what);
        if (got !== want) begin
            $display("mismatch %s: got 0x%h expected 0x%h", what, got, want);
            abort_run();
        end
    endtask

    task automatic check_score(input chart_pkg::score_t got, input chart_pkg::score_t want,
                               input string what);
        if (got !== want) begin
            $display("mismatch %s: got 0x%h expected 0x%h", what, got, want);
            abort_run();
        end
    endtask

    task automatic check_led(input chart_pkg::led_t got, input chart_pkg::led_t want,
                             input string what);
        if (got !== want) begin
            $display("mismatch %s: got 0x%h expected 0x%h", what, got, want);
            abort_run();
        end
    endtask

    task automatic check_digit(input chart_pkg::digit_t got, input chart_pkg::digit_t want,
                               input string what);
        if (got !== want) begin
            $display("mismatch %s: got 0x%h expected 0x%h", what, got, want);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("mismatch %s: got 0x%h expected 0x%h", what, got, want);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // C lights bit 7 and B bit 1
    function automatic chart_pkg::led_t led_for(input chart_pkg::note_t n);
        chart_pkg::led_t l;
        l = '0;
        if (n.keys != 7'd0) begin
            l[0] = n.oct_down | n.oct_up;
            for (int k = 0; k < 7; k++) begin
                l[7 - k] = n.keys[k];
            end
        end
        return l;
    endfunction

    // Each note is judged on the two scan ticks that follow its step tick
    function automatic chart_pkg::score_t model_score(input int n);
        int unsigned      total;
        chart_pkg::note_t cur;
        total = 0;
        for (int j = 1; j <= 2 * n; j++) begin
            cur = chart[(j - 1) / 2];
            if (cur != '0) begin
                if (cur == key_slot[j] || cur == key_slot[j - 1]) begin
                    total += 10;
                end else if (cur == key_slot[j - 2]) begin
                    total += 8;
                end else if (cur == key_slot[j - 3]) begin
                    total += 5;
                end
            end
        end
        return (total > 16383) ? 14'h3fff : chart_pkg::score_t'(total);
    endfunction

    // Offset counts scans before the first judging scan, 4 presses a wrong key
    task automatic schedule_keys(input int n);
        chart_pkg::note_t w;
        for (int m = -3; m <= SLOT_TOP; m++) begin
            key_slot[m] = '0;
        end
        for (int i = 0; i < n; i++) begin
            if (chart[i] != '0) begin
                if (key_ofs[i] >= 4) begin
                    w = chart[i];
                    w.keys = {chart[i].keys[5:0], chart[i].keys[6]};
                    key_slot[2 * i + 1] = w;
                end else begin
                    key_slot[2 * i + 1 - key_ofs[i]] = chart[i];
                end
            end
        end
    endtask

    task automatic make_random_chart(input int n);
        logic [31:0]      r;
        chart_pkg::note_t nt;
        for (int i = 0; i < n; i++) begin
            rng = xorshift(rng);
            r = rng;
            nt = '0;
            // First entry always a rest
            if (i > 0 && r[1:0] != 2'd0) begin
                nt.keys     = 7'd1 << (r[6:4] % 3'd7);
                nt.oct_up   = (r[3:2] == 2'd1);
                nt.oct_down = (r[3:2] == 2'd2);
            end
            chart[i]   = nt;
            key_ofs[i] = int'(r[9:7]) % 5;
        end
    endtask

    task automatic run_chart(input int n, input bit held_tone);
        chart_pkg::score_t model;
        chart_pkg::digit_t want_dig;
        chart_pkg::note_t  cur;
        int unsigned       gap;
        int unsigned       rises_before;
        schedule_keys(n);
        model = model_score(n);
        for (int i = 0; i < n; i++) begin
            @(posedge prog_clk);
            load_en   <= 1'b1;
            load_addr <= chart_pkg::idx_t'(i);
            load_note <= chart[i];
        end
        @(posedge prog_clk);
        load_en    <= 1'b0;
        note_total <= chart_pkg::idx_t'(n);
        start      <= 1'b1;
        @(posedge prog_clk);
        start <= 1'b0;
        @(negedge prog_clk);
        check_digit(digit, 2'd3, "digit");
        check_bit(play_st, 1'b0, "play_st");
        check_score(score, '0, "score");

        // Countdown 3, 2, 1, 0 then play
        want_dig = 2'd3;
        for (int d = 0; d < 4; d++) begin
            gap = 0;
            while (digit == want_dig && !play_st) begin
                @(negedge prog_clk);
                gap++;
            end
            if ((d == 0 && gap > CD_GAP) || (d > 0 && gap != CD_GAP)) begin
                $display("countdown step %0d took %0d cycles instead of %0d", d, gap, CD_GAP);
                abort_run();
            end
            if (d < 3) begin
                want_dig = want_dig - 2'd1;
                check_digit(digit, want_dig, "digit");
                check_bit(play_st, 1'b0, "play_st");
            end else begin
                check_digit(digit, 2'd0, "digit");
                check_bit(play_st, 1'b1, "play_st");
            end
        end

        // First note arrives one step period after play starts
        rises_before = sig_rises;
        repeat (STEP_DIV - 1) @(posedge prog_clk);
        for (int m = 0; m <= 2 * n; m++) begin
            keys <= key_slot[m];
            @(posedge prog_clk);
            @(negedge prog_clk);
            if (m / 2 < n) begin
                cur = chart[m / 2];
            end else begin
                cur = '0;
            end
            if (m % 2 == 0) begin
                check_note(cur_note, cur, "cur_note");
                check_bit(done, m == 2 * n, "done");
            end
            @(posedge prog_clk);
            @(negedge prog_clk);
            if (m % 2 == 0) begin
                check_led(led, led_for(cur), "led");
                if (cur == '0) begin
                    check_bit(sig, 1'b0, "sig");
                end
            end
            repeat (SCAN_DIV - 2) @(posedge prog_clk);
        end
        keys <= '0;
        @(negedge prog_clk);
        check_score(score, model, "score");
        check_bit(done, 1'b1, "done");
        check_bit(sig, 1'b0, "sig");
        if (held_tone && sig_rises == rises_before) begin
            $display("sig never toggled during the held note run");
            abort_run();
        end
    endtask

    initial begin
        int                n_file;
        chart_pkg::score_t file_want;
        rst        = 1'b1;
        start      = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_note  = '0;
        note_total = '0;
        keys       = '0;
        $readmemh("play_vectors.mem", vec);
        repeat (2) @(posedge prog_clk);
        rst <= 1'b0;
        @(negedge prog_clk);
        check_digit(digit, 2'd3, "digit");
        check_bit(play_st, 1'b0, "play_st");
        check_bit(done, 1'b0, "done");
        check_bit(sig, 1'b0, "sig");
        check_score(score, '0, "score");
        check_led(led, '0, "led");
        check_note(cur_note, '0, "cur_note");

        // Directed chart from the vector file
        n_file    = int'(vec[0]);
        file_want = chart_pkg::score_t'(vec[1]);
        for (int i = 0; i < n_file; i++) begin
            chart[i]   = vec[2 + 2 * i][8:0];
            key_ofs[i] = int'(vec[3 + 2 * i]);
        end
        run_chart(n_file, 1'b1);
        check_score(score, file_want, "score");

        make_random_chart(RAND_NOTES);
        run_chart(RAND_NOTES, 1'b0);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- play_vectors.mem
// Word 0 note_total, word 1 expected final score, then one line per chart note
// Note columns: note (oct_down, oct_up, keys C..B from bit 0), key offset 0-3 or 4 wrong key
010
0C2
000 0
001 0
000 0
084 1
000 0
108 2
000 0
040 3
010 4
140 0
140 0
140 0
140 1
140 0
140 0
140 0

//--- vlog.f
chart_pkg.sv
tick_divider.sv
count_down.sv
chart_sequencer.sv
score_judge.sv
note_output.sv
play_chart.sv
tb_play_chart.sv
